// File: hw/isaPkg.sv
package isaPkg;

  typedef enum logic [5:0] {
    opRType = 6'h00,
    opJ     = 6'h02,
    opBeq   = 6'h04,
    opBne   = 6'h05,
    opAddi  = 6'h08,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcodeT;

  typedef enum logic [5:0] {
    fnSll = 6'h00,
    fnSrl = 6'h02,
    fnSra = 6'h03,
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnSlt = 6'h2a
  } functT;

  typedef struct packed {
    opcodeT     opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    functT      funct;
  } rTypeT;

  typedef struct packed {
    opcodeT      opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm; // Also low bits of the jump target
  } iTypeT;

  typedef union packed {
    rTypeT r;
    iTypeT i;
  } instrU;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluSlt,
    aluSll,
    aluSrl,
    aluSra
  } aluOpT;

  typedef enum logic {srcPc, srcRegA} aluSrcAT;

  typedef enum logic [1:0] {srcRegB, srcFour, srcSignImm, srcShiftImm} aluSrcBT;

  typedef enum logic [1:0] {pcAluResult, pcAluOut, pcJump} pcSrcT;

  typedef struct packed {
    logic    pcWrite;
    logic    irWrite;
    logic    regWrite;
    logic    aluOutWrite;
    logic    mdrWrite;
    logic    iorD;     // 1 selects ALUOut as address
    logic    regDst;   // 1 selects rd
    logic    memToReg;
    aluSrcAT aluSrcA;
    aluSrcBT aluSrcB;
    aluOpT   aluOp;
    pcSrcT   pcSource;
  } ctrlT;

endpackage

// File: hw/busPkg.sv
package busPkg;

  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;

  // Master side of AXI4-Lite
  typedef struct packed {
    logic                   awvalid;
    logic [AddrWidth-1:0]   awaddr;
    logic                   wvalid;
    logic [DataWidth-1:0]   wdata;
    logic [DataWidth/8-1:0] wstrb;
    logic                   bready;
    logic                   arvalid;
    logic [AddrWidth-1:0]   araddr;
    logic                   rready;
  } axiReqT;

  // Slave side
  typedef struct packed {
    logic                 awready;
    logic                 wready;
    logic                 bvalid;
    logic [1:0]           bresp;
    logic                 arready;
    logic                 rvalid;
    logic [DataWidth-1:0] rdata;
    logic [1:0]           rresp;
  } axiRspT;

  typedef struct packed {
    logic start; // One-cycle pulse
    logic write;
  } memCmdT;

endpackage

// File: hw/regFile.sv
`timescale 1ns/1ns

module regFile (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  readAddrA,
  input  logic [4:0]  readAddrB,
  input  logic [4:0]  writeAddr,
  input  logic        writeEnable,
  input  logic [31:0] writeData,
  output logic [31:0] readDataA,
  output logic [31:0] readDataB
);

  logic [31:0] regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (writeEnable && writeAddr != 5'd0) begin
      regs[writeAddr] <= writeData; // $0 keeps its reset value
    end
  end

  assign readDataA = regs[readAddrA];
  assign readDataB = regs[readAddrB];

endmodule

// File: hw/alu.sv
`timescale 1ns/1ns

module alu (
  input  isaPkg::aluOpT op,
  input  logic [31:0]   a,
  input  logic [31:0]   b,
  input  logic [4:0]    shamt,
  output logic [31:0]   result,
  output logic          zero
);

  always_comb begin
    case (op)
      isaPkg::aluSub: result = a - b;
      isaPkg::aluAnd: result = a & b;
      isaPkg::aluSlt: result = {31'd0, $signed(a) < $signed(b)};
      // Shifts act on b, as rt in the R-type encoding
      isaPkg::aluSll: result = b << shamt;
      isaPkg::aluSrl: result = b >> shamt;
      isaPkg::aluSra: result = $unsigned($signed(b) >>> shamt);
      default:        result = a + b;
    endcase
  end

  assign zero = (result == 32'd0);

endmodule

// File: hw/dataPath.sv
`timescale 1ns/1ns

module dataPath #(
  parameter logic [busPkg::AddrWidth-1:0] ResetPc = '0
) (
  input  logic                         clock,
  input  logic                         reset,
  input  isaPkg::ctrlT                 ctrl,
  input  logic [busPkg::DataWidth-1:0] rdata,
  input  logic                         memDone,
  output isaPkg::instrU                instr,
  output logic                         zero,
  output logic [busPkg::AddrWidth-1:0] memAddr,
  output logic [busPkg::DataWidth-1:0] memWdata
);

  logic [busPkg::AddrWidth-1:0] pc;
  logic [busPkg::AddrWidth-1:0] pcNext;
  logic [busPkg::AddrWidth-1:0] jumpTarget;
  isaPkg::instrU                ir;
  logic [31:0]                  regA;
  logic [31:0]                  regB;
  logic [31:0]                  aluOut;
  logic [31:0]                  mdr;
  logic [31:0]                  readDataA;
  logic [31:0]                  readDataB;
  logic [31:0]                  signImm;
  logic [31:0]                  aluA;
  logic [31:0]                  aluB;
  logic [31:0]                  aluResult;
  logic [4:0]                   writeReg;
  logic [31:0]                  writeData;

  assign instr      = ir;
  assign signImm    = {{16{ir.i.imm[15]}}, ir.i.imm};
  assign jumpTarget = {pc[31:28], ir.i.rs, ir.i.rt, ir.i.imm, 2'b00};
  assign memAddr    = ctrl.iorD ? aluOut : pc;
  assign memWdata   = regB;
  assign writeReg   = ctrl.regDst ? ir.r.rd : ir.r.rt;
  assign writeData  = ctrl.memToReg ? mdr : aluOut;
  assign aluA       = (ctrl.aluSrcA == isaPkg::srcRegA) ? regA : pc;

  always_comb begin
    case (ctrl.aluSrcB)
      isaPkg::srcFour:     aluB = 32'd4;
      isaPkg::srcSignImm:  aluB = signImm;
      isaPkg::srcShiftImm: aluB = signImm << 2; // Word offset for branches
      default:             aluB = regB;
    endcase
  end

  always_comb begin
    case (ctrl.pcSource)
      isaPkg::pcAluOut: pcNext = aluOut;
      isaPkg::pcJump:   pcNext = jumpTarget;
      default:          pcNext = aluResult;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) pc <= ResetPc;
    else if (ctrl.pcWrite) pc <= pcNext;
  end

  always_ff @(posedge clock) begin
    if (memDone && ctrl.irWrite) ir <= rdata;
    if (memDone && ctrl.mdrWrite) mdr <= rdata;
    if (ctrl.aluOutWrite) aluOut <= aluResult;
    regA <= readDataA; // A and B follow IR every cycle
    regB <= readDataB;
  end

  regFile i_regFile (
    .clock       (clock),
    .reset       (reset),
    .readAddrA   (ir.r.rs),
    .readAddrB   (ir.r.rt),
    .writeAddr   (writeReg),
    .writeEnable (ctrl.regWrite),
    .writeData   (writeData),
    .readDataA   (readDataA),
    .readDataB   (readDataB)
  );

  alu i_alu (
    .op     (ctrl.aluOp),
    .a      (aluA),
    .b      (aluB),
    .shamt  (ir.r.shamt),
    .result (aluResult),
    .zero   (zero)
  );

endmodule

// File: hw/controlFsm.sv
`timescale 1ns/1ns

module controlFsm (
  input  logic           clock,
  input  logic           reset,
  input  isaPkg::instrU  instr,
  input  logic           zero,
  input  logic           memDone,
  output isaPkg::ctrlT   ctrl,
  output busPkg::memCmdT memCmd
);

  typedef enum logic [3:0] {
    fetch,
    fetchWait,
    decode,
    execR,
    execAddi,
    execBranch,
    execJump,
    memAddr,
    memIssue,
    memWait,
    loadWrite,
    writeback
  } stateT;

  stateT state;
  stateT stateNext;
  logic  started;
  logic  isStore;

  function automatic isaPkg::aluOpT functToOp(isaPkg::functT funct);
    case (funct)
      isaPkg::fnSub: return isaPkg::aluSub;
      isaPkg::fnAnd: return isaPkg::aluAnd;
      isaPkg::fnSlt: return isaPkg::aluSlt;
      isaPkg::fnSll: return isaPkg::aluSll;
      isaPkg::fnSrl: return isaPkg::aluSrl;
      isaPkg::fnSra: return isaPkg::aluSra;
      default:       return isaPkg::aluAdd;
    endcase
  endfunction

  assign isStore = (instr.i.opcode == isaPkg::opSw);

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= fetch;
      started <= 1'b0;
    end else begin
      state   <= stateNext;
      started <= 1'b1; // First fetch waits one cycle out of reset
    end
  end

  always_comb begin
    ctrl          = '0;
    ctrl.aluSrcA  = isaPkg::srcPc;
    ctrl.aluSrcB  = isaPkg::srcRegB;
    ctrl.aluOp    = isaPkg::aluAdd;
    ctrl.pcSource = isaPkg::pcAluResult;
    memCmd        = '0;
    stateNext     = state;

    case (state)
      fetch: begin
        if (started) begin
          memCmd.start  = 1'b1;
          ctrl.pcWrite  = 1'b1; // PC + 4 while the bridge takes the old PC
          ctrl.aluSrcB  = isaPkg::srcFour;
          stateNext     = fetchWait;
        end
      end
      fetchWait: begin
        ctrl.irWrite = 1'b1;
        if (memDone) stateNext = decode;
      end
      decode: begin
        // Branch target into ALUOut
        ctrl.aluSrcB     = isaPkg::srcShiftImm;
        ctrl.aluOutWrite = 1'b1;
        case (instr.i.opcode)
          isaPkg::opRType: begin
            case (instr.r.funct)
              isaPkg::fnAdd, isaPkg::fnSub, isaPkg::fnAnd, isaPkg::fnSlt,
              isaPkg::fnSll, isaPkg::fnSrl, isaPkg::fnSra: stateNext = execR;
              default: stateNext = fetch;
            endcase
          end
          isaPkg::opAddi:             stateNext = execAddi;
          isaPkg::opLw, isaPkg::opSw: stateNext = memAddr;
          isaPkg::opBeq, isaPkg::opBne: stateNext = execBranch;
          isaPkg::opJ:                stateNext = execJump;
          default:                    stateNext = fetch; // Unknown opcode is a no-op
        endcase
      end
      execR: begin
        ctrl.aluSrcA     = isaPkg::srcRegA;
        ctrl.aluSrcB     = isaPkg::srcRegB;
        ctrl.aluOp       = functToOp(instr.r.funct);
        ctrl.aluOutWrite = 1'b1;
        stateNext        = writeback;
      end
      execAddi: begin
        ctrl.aluSrcA     = isaPkg::srcRegA;
        ctrl.aluSrcB     = isaPkg::srcSignImm;
        ctrl.aluOutWrite = 1'b1;
        stateNext        = writeback;
      end
      execBranch: begin
        ctrl.aluSrcA  = isaPkg::srcRegA;
        ctrl.aluSrcB  = isaPkg::srcRegB;
        ctrl.aluOp    = isaPkg::aluSub;
        ctrl.pcSource = isaPkg::pcAluOut;
        ctrl.pcWrite  = (instr.i.opcode == isaPkg::opBeq) ? zero : !zero;
        stateNext     = fetch;
      end
      execJump: begin
        ctrl.pcSource = isaPkg::pcJump;
        ctrl.pcWrite  = 1'b1;
        stateNext     = fetch;
      end
      memAddr: begin
        ctrl.aluSrcA     = isaPkg::srcRegA;
        ctrl.aluSrcB     = isaPkg::srcSignImm;
        ctrl.aluOutWrite = 1'b1;
        stateNext        = memIssue;
      end
      memIssue: begin
        ctrl.iorD    = 1'b1;
        memCmd.start = 1'b1;
        memCmd.write = isStore;
        stateNext    = memWait;
      end
      memWait: begin
        ctrl.iorD     = 1'b1;
        ctrl.mdrWrite = !isStore;
        if (memDone) stateNext = isStore ? fetch : loadWrite;
      end
      loadWrite: begin
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = 1'b1; // rt gets MDR
        stateNext     = fetch;
      end
      writeback: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = (instr.i.opcode == isaPkg::opRType);
        stateNext     = fetch;
      end
      default: stateNext = fetch;
    endcase
  end

endmodule

// File: hw/memBridge.sv
`timescale 1ns/1ns

module memBridge (
  input  logic                         clock,
  input  logic                         reset,
  input  busPkg::memCmdT               memCmd,
  input  logic [busPkg::AddrWidth-1:0] memAddr,
  input  logic [busPkg::DataWidth-1:0] memWdata,
  output logic                         memDone,
  output logic [busPkg::DataWidth-1:0] rdata,
  output busPkg::axiReqT               axiReq,
  input  busPkg::axiRspT               axiRsp
);

  typedef enum logic [1:0] {busIdle, busRead, busWrite} stateT;

  stateT                        state;
  logic                         addrDone; // AW or AR accepted
  logic                         dataDone; // W accepted
  logic [busPkg::AddrWidth-1:0] addrReg;
  logic [busPkg::DataWidth-1:0] dataReg;

  always_comb begin
    axiReq         = '0;
    axiReq.awvalid = (state == busWrite) && !addrDone;
    axiReq.awaddr  = addrReg;
    axiReq.wvalid  = (state == busWrite) && !dataDone;
    axiReq.wdata   = dataReg;
    axiReq.wstrb   = '1;
    axiReq.bready  = (state == busWrite);
    axiReq.arvalid = (state == busRead) && !addrDone;
    axiReq.araddr  = addrReg;
    axiReq.rready  = (state == busRead) && addrDone;
  end

  // Done in the cycle of the R or B handshake
  assign memDone = (axiReq.rready && axiRsp.rvalid) || (axiReq.bready && axiRsp.bvalid);
  assign rdata   = axiRsp.rdata;

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= busIdle;
      addrDone <= 1'b0;
      dataDone <= 1'b0;
    end else begin
      case (state)
        busIdle: begin
          if (memCmd.start) begin
            state    <= memCmd.write ? busWrite : busRead;
            addrDone <= 1'b0;
            dataDone <= 1'b0;
          end
        end
        busRead: begin
          if (axiReq.arvalid && axiRsp.arready) addrDone <= 1'b1;
          if (memDone) state <= busIdle;
        end
        busWrite: begin
          if (axiReq.awvalid && axiRsp.awready) addrDone <= 1'b1;
          if (axiReq.wvalid && axiRsp.wready) dataDone <= 1'b1;
          if (memDone) state <= busIdle;
        end
        default: state <= busIdle;
      endcase
    end
  end

  // Held stable for the whole transaction
  always_ff @(posedge clock) begin
    if (state == busIdle && memCmd.start) begin
      addrReg <= memAddr;
      dataReg <= memWdata;
    end
  end

endmodule

// File: hw/cpuTop.sv
`timescale 1ns/1ns

module cpuTop #(
  parameter logic [31:0] ResetPc = 32'hbfc0_0000
) (
  input  logic           clock,
  input  logic           reset,
  output busPkg::axiReqT axiReq,
  input  busPkg::axiRspT axiRsp
);

  isaPkg::ctrlT                 ctrl;
  isaPkg::instrU                instr;
  logic                         zero;
  busPkg::memCmdT               memCmd;
  logic                         memDone;
  logic [busPkg::DataWidth-1:0] rdata;
  logic [busPkg::AddrWidth-1:0] memAddr;
  logic [busPkg::DataWidth-1:0] memWdata;

  controlFsm i_control (
    .clock   (clock),
    .reset   (reset),
    .instr   (instr),
    .zero    (zero),
    .memDone (memDone),
    .ctrl    (ctrl),
    .memCmd  (memCmd)
  );

  dataPath #(.ResetPc(ResetPc)) i_dataPath (
    .clock    (clock),
    .reset    (reset),
    .ctrl     (ctrl),
    .rdata    (rdata),
    .memDone  (memDone),
    .instr    (instr),
    .zero     (zero),
    .memAddr  (memAddr),
    .memWdata (memWdata)
  );

  memBridge i_memBridge (
    .clock    (clock),
    .reset    (reset),
    .memCmd   (memCmd),
    .memAddr  (memAddr),
    .memWdata (memWdata),
    .memDone  (memDone),
    .rdata    (rdata),
    .axiReq   (axiReq),
    .axiRsp   (axiRsp)
  );

endmodule

// File: dv/memBridge_assert.sv
`timescale 1ns/1ns

module memBridgeAssert (
  input logic           clock,
  input logic           reset,
  input busPkg::axiReqT axiReq,
  input busPkg::axiRspT axiRsp
);

  arHold: assert property (@(posedge clock) disable iff (reset)
    axiReq.arvalid && !axiRsp.arready |=> axiReq.arvalid && $stable(axiReq.araddr))
    else $error("AR valid dropped or address changed before arready");

  awHold: assert property (@(posedge clock) disable iff (reset)
    axiReq.awvalid && !axiRsp.awready |=> axiReq.awvalid && $stable(axiReq.awaddr))
    else $error("AW valid dropped or address changed before awready");

  wHold: assert property (@(posedge clock) disable iff (reset)
    axiReq.wvalid && !axiRsp.wready |=> axiReq.wvalid && $stable(axiReq.wdata))
    else $error("W valid dropped or data changed before wready");

  // One outstanding transaction
  oneChannel: assert property (@(posedge clock) disable iff (reset)
    !(axiReq.arvalid && axiReq.awvalid))
    else $error("Read and write address valid high together");

  quietAfterReset: assert property (@(posedge clock)
    reset |=> !(axiReq.arvalid || axiReq.awvalid || axiReq.wvalid))
    else $error("Valid high in the cycle after reset");

endmodule

bind memBridge memBridgeAssert i_memBridgeAssert (
  .clock  (clock),
  .reset  (reset),
  .axiReq (axiReq),
  .axiRsp (axiRsp)
);

// File: dv/cpuTb.sv
`timescale 1ns/1ns

module cpuTb;

  typedef enum logic [3:0] {
    tAdd, tSub, tAnd, tSlt, tSll, tSrl, tSra, tAddi, tBeq, tBne
  } testOpT;

  typedef struct packed {
    testOpT      op;
    logic [31:0] a;
    logic [31:0] b;
    logic [15:0] imm; // Also shamt for shifts
    logic [31:0] expected;
  } testT;

  logic                         clock;
  logic                         reset = 1'b1;
  busPkg::axiReqT               axiReq;
  busPkg::axiRspT               axiRsp = '0;

  testT                         tests[$];
  string                        testNames[$];
  logic [31:0]                  mem [256];
  logic [31:0]                  lcgState = 32'd1;
  int unsigned                  cycleCount = 0;
  int unsigned                  cycleLimit;
  int                           passCount = 0;
  int                           failCount = 0;

  // Slave model state
  logic                         readBusy;
  logic                         awGot;
  logic                         wGot;
  logic [1:0]                   arCount;
  logic [1:0]                   rCount;
  logic [1:0]                   awCount;
  logic [1:0]                   wCount;
  logic [1:0]                   bCount;
  logic [busPkg::AddrWidth-1:0] readAddr;
  logic [busPkg::AddrWidth-1:0] awAddr;
  logic [busPkg::DataWidth-1:0] wData;
  logic [busPkg::DataWidth/8-1:0] wStrb;
  logic                         storeSeen;
  logic [busPkg::AddrWidth-1:0] storeAddr;
  logic [busPkg::DataWidth-1:0] storeData;
  logic [busPkg::DataWidth/8-1:0] storeStrb;

  cpuTop #(.ResetPc(32'h0)) i_dut (
    .clock  (clock),
    .reset  (reset),
    .axiReq (axiReq),
    .axiRsp (axiRsp)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [31:0] lcgNext(logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Reference results from the ISA rules
  function automatic logic [31:0] modelResult(testOpT op, logic [31:0] a, logic [31:0] b,
                                              logic [15:0] imm);
    case (op)
      tSub:    return a - b;
      tAnd:    return a & b;
      tSlt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      tSll:    return b << imm[4:0];
      tSrl:    return b >> imm[4:0];
      tSra:    return $signed(b) >>> imm[4:0];
      tAddi:   return a + {{16{imm[15]}}, imm};
      tBeq:    return (a == b) ? 32'd0 : 32'd1; // Taken branch skips the addi
      tBne:    return (a != b) ? 32'd0 : 32'd1;
      default: return a + b;
    endcase
  endfunction

  function automatic logic [31:0] iWord(isaPkg::opcodeT opcode, logic [4:0] rs, logic [4:0] rt,
                                        logic [15:0] imm);
    isaPkg::instrU word;
    word.i.opcode = opcode;
    word.i.rs     = rs;
    word.i.rt     = rt;
    word.i.imm    = imm;
    return word;
  endfunction

  // Operation under test writes $3
  function automatic logic [31:0] encodeOp(testOpT op, logic [15:0] imm);
    isaPkg::instrU word;
    word = '0;
    if (op == tAddi) return iWord(isaPkg::opAddi, 5'd1, 5'd3, imm);
    if (op == tBeq) return iWord(isaPkg::opBeq, 5'd1, 5'd2, 16'd1);
    if (op == tBne) return iWord(isaPkg::opBne, 5'd1, 5'd2, 16'd1);
    word.r.opcode = isaPkg::opRType;
    word.r.rs     = 5'd1;
    word.r.rt     = 5'd2;
    word.r.rd     = 5'd3;
    word.r.shamt  = imm[4:0];
    case (op)
      tSub:    word.r.funct = isaPkg::fnSub;
      tAnd:    word.r.funct = isaPkg::fnAnd;
      tSlt:    word.r.funct = isaPkg::fnSlt;
      tSll:    word.r.funct = isaPkg::fnSll;
      tSrl:    word.r.funct = isaPkg::fnSrl;
      tSra:    word.r.funct = isaPkg::fnSra;
      default: word.r.funct = isaPkg::fnAdd;
    endcase
    return word;
  endfunction

  task automatic addTest(input string name, input testOpT op, input logic [31:0] a,
                         input logic [31:0] b, input logic [15:0] imm);
    testT entry;
    entry.op       = op;
    entry.a        = a;
    entry.b        = b;
    entry.imm      = imm;
    entry.expected = modelResult(op, a, b, imm);
    tests.push_back(entry);
    testNames.push_back(name);
  endtask

  task automatic loadProgram(input testT entry);
    mem[0] = iWord(isaPkg::opLw, 5'd0, 5'd1, 16'h0100);
    mem[1] = iWord(isaPkg::opLw, 5'd0, 5'd2, 16'h0104);
    mem[2] = encodeOp(entry.op, entry.imm);
    if (entry.op == tBeq || entry.op == tBne) mem[3] = iWord(isaPkg::opAddi, 5'd0, 5'd3, 16'd1);
    else mem[3] = 32'd0; // sll $0 as a no-op
    mem[4]  = iWord(isaPkg::opSw, 5'd0, 5'd3, 16'h0108);
    mem[5]  = iWord(isaPkg::opJ, 5'd0, 5'd0, 16'd5); // Jump to itself at 0x14
    mem[64] = entry.a;
    mem[65] = entry.b;
  endtask

  task automatic compareData(input string name, input logic [busPkg::DataWidth-1:0] expected,
                             input logic [busPkg::DataWidth-1:0] actual, inout bit ok);
    if (actual !== expected) begin
      $display("[FAIL] %s: store data expected %h, actual %h", name, expected, actual);
      ok = 1'b0;
    end
  endtask

  task automatic verifyAddress(input string name, input logic [busPkg::AddrWidth-1:0] expected,
                               input logic [busPkg::AddrWidth-1:0] actual, inout bit ok);
    if (actual !== expected) begin
      $display("[FAIL] %s: store address expected %h, actual %h", name, expected, actual);
      ok = 1'b0;
    end
  endtask

  task automatic compareStrobe(input string name,
                               input logic [busPkg::DataWidth/8-1:0] expected,
                               input logic [busPkg::DataWidth/8-1:0] actual, inout bit ok);
    if (actual !== expected) begin
      $display("[FAIL] %s: write strobe expected %h, actual %h", name, expected, actual);
      ok = 1'b0;
    end
  endtask

  // AXI4-Lite slave with random ready and valid delays
  always @(posedge clock) begin
    lcgState = lcgNext(lcgState);
    if (reset) begin
      axiRsp    <= '0;
      readBusy  <= 1'b0;
      awGot     <= 1'b0;
      wGot      <= 1'b0;
      storeSeen <= 1'b0;
      arCount   <= lcgState[17:16];
      rCount    <= lcgState[19:18];
      awCount   <= lcgState[21:20];
      wCount    <= lcgState[23:22];
      bCount    <= lcgState[25:24];
    end else begin
      if (axiReq.arvalid && axiRsp.arready) begin
        axiRsp.arready <= 1'b0;
        readAddr       <= axiReq.araddr;
        readBusy       <= 1'b1;
        arCount        <= lcgState[17:16];
      end else if (axiReq.arvalid && !readBusy) begin
        if (arCount == 2'd0) axiRsp.arready <= 1'b1;
        else arCount <= arCount - 2'd1;
      end
      if (readBusy && !axiRsp.rvalid) begin
        if (rCount == 2'd0) begin
          axiRsp.rvalid <= 1'b1;
          axiRsp.rdata  <= mem[readAddr[9:2]];
        end else begin
          rCount <= rCount - 2'd1;
        end
      end
      if (axiRsp.rvalid && axiReq.rready) begin
        axiRsp.rvalid <= 1'b0;
        readBusy      <= 1'b0;
        rCount        <= lcgState[19:18];
      end
      if (axiReq.awvalid && axiRsp.awready) begin
        axiRsp.awready <= 1'b0;
        awAddr         <= axiReq.awaddr;
        awGot          <= 1'b1;
        awCount        <= lcgState[21:20];
      end else if (axiReq.awvalid && !awGot) begin
        if (awCount == 2'd0) axiRsp.awready <= 1'b1;
        else awCount <= awCount - 2'd1;
      end
      if (axiReq.wvalid && axiRsp.wready) begin
        axiRsp.wready <= 1'b0;
        wData         <= axiReq.wdata;
        wStrb         <= axiReq.wstrb;
        wGot          <= 1'b1;
        wCount        <= lcgState[23:22];
      end else if (axiReq.wvalid && !wGot) begin
        if (wCount == 2'd0) axiRsp.wready <= 1'b1;
        else wCount <= wCount - 2'd1;
      end
      // Write beats are captured for checking and never stored in mem
      if (awGot && wGot && !axiRsp.bvalid) begin
        if (bCount == 2'd0) begin
          axiRsp.bvalid <= 1'b1;
          storeSeen     <= 1'b1;
          storeAddr     <= awAddr;
          storeData     <= wData;
          storeStrb     <= wStrb;
        end else begin
          bCount <= bCount - 2'd1;
        end
      end
      if (axiRsp.bvalid && axiReq.bready) begin
        axiRsp.bvalid <= 1'b0;
        awGot         <= 1'b0;
        wGot          <= 1'b0;
        bCount        <= lcgState[25:24];
      end
    end
  end

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout after %0d cycles, a store never arrived", cycleLimit);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    bit ok;
    addTest("add_small", tAdd, 32'd5, 32'd7, 16'd0);
    addTest("add_carry", tAdd, 32'hffff_ffff, 32'd2, 16'd0);
    addTest("sub_basic", tSub, 32'd100, 32'd58, 16'd0);
    addTest("sub_wrap", tSub, 32'd3, 32'd10, 16'd0);
    addTest("and_mask", tAnd, 32'hf0f0_1234, 32'h0ff0_ff00, 16'd0);
    addTest("slt_neg_pos", tSlt, 32'hffff_fffb, 32'd3, 16'd0);
    addTest("slt_pos_neg", tSlt, 32'd3, 32'hffff_fffb, 16'd0);
    addTest("slt_extremes", tSlt, 32'h7fff_ffff, 32'h8000_0000, 16'd0);
    addTest("sll_4", tSll, 32'd0, 32'h0000_00ff, 16'd4);
    addTest("srl_31", tSrl, 32'd0, 32'h8000_0000, 16'd31);
    addTest("sra_neg", tSra, 32'd0, 32'hf000_0000, 16'd8);
    addTest("sra_pos", tSra, 32'd0, 32'h7000_0000, 16'd4);
    addTest("addi_neg", tAddi, 32'd100, 32'd0, 16'hfffd);
    addTest("addi_min", tAddi, 32'd0, 32'd0, 16'h8000);
    addTest("beq_taken", tBeq, 32'd9, 32'd9, 16'd0);
    addTest("beq_not", tBeq, 32'd9, 32'd8, 16'd0);
    addTest("bne_taken", tBne, 32'd9, 32'd8, 16'd0);
    addTest("bne_not", tBne, 32'd9, 32'd9, 16'd0);
    cycleLimit = 400 * tests.size();
    for (int k = 0; k < 256; k++) begin
      mem[k] = 32'hfc00_0000 | k; // Unused opcode tagged with the word index
    end

    for (int t = 0; t < tests.size(); t++) begin
      @(posedge clock);
      reset <= 1'b1;
      loadProgram(tests[t]);
      repeat (2) @(posedge clock);
      reset <= 1'b0;
      while (!storeSeen) @(posedge clock);
      ok = 1'b1;
      compareData(testNames[t], tests[t].expected, storeData, ok);
      verifyAddress(testNames[t], 32'h0000_0108, storeAddr, ok);
      compareStrobe(testNames[t], 4'hf, storeStrb, ok);
      if (ok) begin
        passCount++;
        $display("[PASS] %s stored %h", testNames[t], storeData);
      end else begin
        failCount++;
      end
    end

    $display("Tests run: %0d, passed: %0d, failed: %0d", tests.size(), passCount, failCount);
    if (failCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
hw/isaPkg.sv
hw/busPkg.sv
hw/regFile.sv
hw/alu.sv
hw/dataPath.sv
hw/controlFsm.sv
hw/memBridge.sv
hw/cpuTop.sv
dv/memBridge_assert.sv
dv/cpuTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module cpuTb -o cpuSim
output=$(./obj_dir/cpuSim 2>&1) || true
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx "Verification passed"
